/* vlog.f */
src/dozePkg.sv
src/settleIf.sv
src/wakeSourceMonitor.sv
src/clkSettleTimer.sv
src/dozeController.sv
src/dozeTop.sv
dv/dozeTb_sva.sv
dv/dozeTb.sv

/* Makefile */
# Verilator build and run for the doze sequencer testbench

TOP = dozeTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; status=$$?; echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

/* dv/dozeTb.sv */
/*
  Directed testbench for the doze sequencer with default parameters.
  Inputs change on the rising edge, outputs are sampled on the falling edge.
  Timing rules are checked by the bound assertions, end states here.
*/

module dozeTb;

  logic       macLPClk;
  logic       macCoreClkHardRst_n;
  logic       macCoreClkSoftRst_n;
  // 0 listen, 1 DTIM, 2 ATIM over, 3 abs timer, 4 register wake
  logic [dozePkg::NUM_WAKE_SRC-1:0] srcPulse;
  logic [dozePkg::NUM_WAKE_SRC-1:0] wakeEnMask;
  logic       moveToDoze_p;
  logic       wakeUpSW;
  logic       enableLPClkSwitch;
  logic       activeClkGating;
  logic       fastClkStable;
  logic [3:0] nextState;
  logic       dozeWakeUp_p;
  logic       macPriClkEn;
  logic       macSecClkEn;
  logic       platformWakeUp;
  logic       macLPClkSwitch;
  logic [dozePkg::NUM_WAKE_SRC-1:0] wakeCause;
  dozePkg::dozeStateE dozeState;

  int     passCount;
  int     failCount;
  int     errCount;
  int     cycleCount;
  int     cycleLimit;
  int     lpCycles;
  int     fastCycles;
  integer seed;
  bit     ok;

  dozeTop UUT
  (
    .macLPClk               (macLPClk),
    .macCoreClkHardRst_n    (macCoreClkHardRst_n),
    .macCoreClkSoftRst_n    (macCoreClkSoftRst_n),
    .wakeupListenInterval_p (srcPulse[0]),
    .wakeupDTIM_p           (srcPulse[1]),
    .atimWindowOver_p       (srcPulse[2]),
    .absGenTimersInt        (srcPulse[3]),
    .wakeUpFromDoze         (srcPulse[4]),
    .wakeEnMask             (wakeEnMask),
    .moveToDoze_p           (moveToDoze_p),
    .wakeUpSW               (wakeUpSW),
    .enableLPClkSwitch      (enableLPClkSwitch),
    .activeClkGating        (activeClkGating),
    .fastClkStable          (fastClkStable),
    .nextState              (nextState),
    .dozeWakeUp_p           (dozeWakeUp_p),
    .macPriClkEn            (macPriClkEn),
    .macSecClkEn            (macSecClkEn),
    .platformWakeUp         (platformWakeUp),
    .macLPClkSwitch         (macLPClkSwitch),
    .wakeCause              (wakeCause),
    .dozeState              (dozeState)
  );

  initial
  begin
    macLPClk = 1'b0;
    forever #4 macLPClk = ~macLPClk;
  end

  //////////////////////////////
  // Watchdog
  //////////////////////////////

  always @(posedge macLPClk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit > 0 && cycleCount > cycleLimit)
    begin
      $display("Run stopped: no finish within %0d cycles", cycleLimit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Polls the state on falling edges up to bound cycles
  task automatic waitForState(input dozePkg::dozeStateE target, input int bound,
                              output bit found);
    int n;
    begin
      found = 1'b0;
      n = 0;
      while (!found && n < bound)
      begin
        @(negedge macLPClk);
        found = (dozeState == target);
        n++;
      end
    end
  endtask

  task automatic waitForWakePulse(input int bound, output bit found);
    int n;
    begin
      found = 1'b0;
      n = 0;
      while (!found && n < bound)
      begin
        @(negedge macLPClk);
        found = dozeWakeUp_p;
        n++;
      end
    end
  endtask

  task automatic pulseSource(input int idx);
    begin
      @(posedge macLPClk);
      srcPulse[idx] <= 1'b1;
      @(posedge macLPClk);
      srcPulse[idx] <= 1'b0;
    end
  endtask

  task automatic requestDoze();
    begin
      @(posedge macLPClk);
      moveToDoze_p <= 1'b1;
      @(posedge macLPClk);
      moveToDoze_p <= 1'b0;
    end
  endtask

  // Random idle gap before a wake source fires
  task automatic randomGap();
    int gap;
    begin
      gap = 2 + ($unsigned($random(seed)) % 8);
      repeat (gap) @(posedge macLPClk);
    end
  endtask

  task automatic checkValue(input bit cond, input string what);
    begin
      assert (cond)
      else
      begin
        $display("** Error at %0t: %s", $time, what);
        errCount++;
      end
    end
  endtask

  task automatic reportTest(input string name, input bit reached, input int errBefore);
    begin
      if (!reached)
      begin
        $display("Test %s: expected end event never came", name);
        failCount++;
      end
      else if (errCount != errBefore)
      begin
        $display("Test %s: finished with errors", name);
        failCount++;
      end
      else
      begin
        $display("Test %s: finished", name);
        passCount++;
      end
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial
  begin
    int e;
    int entryBound;
    int wakeBound;
    passCount = 0;
    failCount = 0;
    errCount = 0;
    cycleCount = 0;
    seed = 32'he7b4_56f7;
    lpCycles = UUT.toLpCycles;
    fastCycles = UUT.toFastCycles;
    entryBound = lpCycles + 6;
    wakeBound = fastCycles + 20;
    // Reset, six tests with entry, wake, gap and hold margins
    cycleLimit = 10 + 6 * (entryBound + wakeBound + 40);
    macCoreClkHardRst_n <= 1'b0;
    macCoreClkSoftRst_n <= 1'b1;
    srcPulse <= '0;
    // Listen interval and register wake masked off
    wakeEnMask <= 5'b01110;
    moveToDoze_p <= 1'b0;
    wakeUpSW <= 1'b0;
    enableLPClkSwitch <= 1'b1;
    activeClkGating <= 1'b1;
    fastClkStable <= 1'b1;
    nextState <= 4'd1;

    // Reset values during and after reset
    e = errCount;
    repeat (4) @(posedge macLPClk);
    @(negedge macLPClk);
    checkValue(macPriClkEn && macSecClkEn && platformWakeUp, "enables low in reset");
    @(posedge macLPClk);
    macCoreClkHardRst_n <= 1'b1;
    @(negedge macLPClk);
    checkValue(!dozeWakeUp_p && !macLPClkSwitch, "pulse or LP switch after reset");
    reportTest("reset", dozeState == dozePkg::IDLE, e);

    // Doze entry with gating
    e = errCount;
    requestDoze();
    waitForState(dozePkg::DOZE, entryBound, ok);
    if (ok)
    begin
      @(negedge macLPClk);
      checkValue(!macPriClkEn && !macSecClkEn, "enables not gated in DOZE");
    end
    reportTest("entry", ok, e);

    // Wake held off by fastClkStable
    e = errCount;
    @(posedge macLPClk);
    fastClkStable <= 1'b0;
    randomGap();
    pulseSource(1);
    waitForState(dozePkg::SWITCHONCLK, wakeBound, ok);
    repeat (5) @(negedge macLPClk);
    checkValue(!dozeWakeUp_p, "wake pulse while fast clock unstable");
    @(posedge macLPClk);
    fastClkStable <= 1'b1;
    if (ok)
      waitForWakePulse(4, ok);
    @(negedge macLPClk);
    @(negedge macLPClk);
    checkValue(macPriClkEn && macSecClkEn, "enables not restored after wake");
    checkValue(wakeCause[1], "DTIM cause not recorded");
    reportTest("wake", ok, e);

    // Masked source ignored, enabled one wakes
    e = errCount;
    requestDoze();
    waitForState(dozePkg::DOZE, entryBound, ok);
    pulseSource(0);
    repeat (4) @(negedge macLPClk);
    checkValue(!platformWakeUp, "masked source woke the platform");
    checkValue(!wakeCause[0], "masked source recorded as cause");
    randomGap();
    pulseSource(3);
    if (ok)
      waitForWakePulse(wakeBound, ok);
    checkValue(wakeCause[3], "abs timer cause not recorded");
    reportTest("masked", ok, e);

    // Software hold in WAITSWREQ
    e = errCount;
    @(posedge macLPClk);
    wakeUpSW <= 1'b1;
    requestDoze();
    waitForState(dozePkg::DOZE, entryBound, ok);
    pulseSource(2);
    if (ok)
      waitForState(dozePkg::WAITSWREQ, 6, ok);
    repeat (6)
    begin
      @(negedge macLPClk);
      checkValue(platformWakeUp && !dozeWakeUp_p, "WAITSWREQ hold broken");
    end
    @(posedge macLPClk);
    nextState <= 4'd0;
    if (ok)
      waitForWakePulse(wakeBound, ok);
    @(posedge macLPClk);
    nextState <= 4'd1;
    wakeUpSW <= 1'b0;
    reportTest("swHold", ok, e);

    // Gating off, enables stay up
    e = errCount;
    activeClkGating <= 1'b0;
    // LP switch request off, so the switch output must stay low
    enableLPClkSwitch <= 1'b0;
    requestDoze();
    waitForState(dozePkg::DOZE, entryBound, ok);
    checkValue(!platformWakeUp, "platformWakeUp high in DOZE");
    randomGap();
    pulseSource(1);
    if (ok)
      waitForWakePulse(wakeBound, ok);
    checkValue(macPriClkEn && macSecClkEn, "enables gated with gating off");
    reportTest("noGating", ok, e);

    $display("Tests passed %0d failed %0d", passCount, failCount);
    if (failCount == 0 && errCount == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* dv/dozeTb_sva.sv */
/*
  Concurrent checks on the doze sequencer top-level ports.
  Bound into dozeTop so the settle parameters follow the instance.
  Sampled on macLPClk; inputs are assumed to change right after the edge.
*/

module dozeSva
#(
  parameter int toLpCycles   = 6,
  parameter int toFastCycles = 4
)
(
  input logic               macLPClk,
  input logic               macCoreClkHardRst_n,
  input logic               moveToDoze_p,
  input logic               enableLPClkSwitch,
  input logic               activeClkGating,
  input logic               fastClkStable,
  input logic               dozeWakeUp_p,
  input logic               macPriClkEn,
  input logic               macSecClkEn,
  input logic               platformWakeUp,
  input logic               macLPClkSwitch,
  input dozePkg::dozeStateE dozeState
);

  //////////////////////////////
  // Reset values
  //////////////////////////////

  // Held in reset last cycle, so outputs must show reset values now
  resetVals: assert property (@(posedge macLPClk)
    $past(!macCoreClkHardRst_n) |->
      (macPriClkEn && macSecClkEn && platformWakeUp && !dozeWakeUp_p && !macLPClkSwitch))
    else $error("Outputs not at reset values");

  //////////////////////////////
  // Doze entry
  //////////////////////////////

  // Accepted request, platformWakeUp drops toLpCycles + 2 after drive edge
  entryLatency: assert property (@(posedge macLPClk) disable iff (!macCoreClkHardRst_n)
    (moveToDoze_p && dozeState == dozePkg::IDLE) |->
      ##(toLpCycles + 1) platformWakeUp ##1 !platformWakeUp)
    else $error("platformWakeUp fall latency wrong");

  // Secondary already gated a cycle before primary goes off
  secBeforePri: assert property (@(posedge macLPClk) disable iff (!macCoreClkHardRst_n)
    $fell(macPriClkEn) |-> $past(!macSecClkEn))
    else $error("macPriClkEn fell before macSecClkEn");

  lpSwitchFollow: assert property (@(posedge macLPClk) disable iff (!macCoreClkHardRst_n)
    !platformWakeUp |-> (macLPClkSwitch == enableLPClkSwitch))
    else $error("macLPClkSwitch differs from enableLPClkSwitch while asleep");

  //////////////////////////////
  // Wake pulse
  //////////////////////////////

  wakePulseOne: assert property (@(posedge macLPClk) disable iff (!macCoreClkHardRst_n)
    dozeWakeUp_p |-> (fastClkStable ##1 !dozeWakeUp_p))
    else $error("dozeWakeUp_p without fastClkStable or longer than one cycle");

  // Fast settle must have run in full before the pulse
  wakePulseLate: assert property (@(posedge macLPClk) disable iff (!macCoreClkHardRst_n)
    dozeWakeUp_p |->
      ($past(dozeState, toFastCycles + 1) == dozePkg::SWITCHTOFASTCLK ||
       $past(dozeState, toFastCycles + 1) == dozePkg::SWITCHONCLK))
    else $error("dozeWakeUp_p earlier than the fast clock settle");

  //////////////////////////////
  // Gating off
  //////////////////////////////

  noGating: assert property (@(posedge macLPClk) disable iff (!macCoreClkHardRst_n)
    (!activeClkGating && $past(!activeClkGating)) |-> (macPriClkEn && macSecClkEn))
    else $error("Clock enable dropped with gating off");

endmodule

bind dozeTop dozeSva #(.toLpCycles(toLpCycles), .toFastCycles(toFastCycles)) uDozeSva (.*);

/* src/dozeTop.sv */
/*
  Doze sequencer top level, single clock domain on macLPClk.
  All inputs must be synchronous to macLPClk.
  Soft reset is a synchronous clear, hard reset is asynchronous.
*/

module dozeTop
#(
  parameter int counterWidth = 8,
  parameter int toLpCycles   = 6,
  parameter int toFastCycles = 4
)
(
  input  logic                              macLPClk,
  input  logic                              macCoreClkHardRst_n,
  input  logic                              macCoreClkSoftRst_n,
  // Wake sources
  input  logic                              wakeupListenInterval_p,
  input  logic                              wakeupDTIM_p,
  input  logic                              atimWindowOver_p,
  input  logic                              absGenTimersInt,
  input  logic                              wakeUpFromDoze,
  input  logic [dozePkg::NUM_WAKE_SRC-1:0]  wakeEnMask,
  // MAC controller and registers
  input  logic                              moveToDoze_p,
  input  logic                              wakeUpSW,
  input  logic                              enableLPClkSwitch,
  input  logic                              activeClkGating,
  input  logic                              fastClkStable,
  input  logic [3:0]                        nextState,
  output logic                              dozeWakeUp_p,
  // Clock controller
  output logic                              macPriClkEn,
  output logic                              macSecClkEn,
  output logic                              platformWakeUp,
  output logic                              macLPClkSwitch,
  // Status and debug
  output logic [dozePkg::NUM_WAKE_SRC-1:0]  wakeCause,
  output dozePkg::dozeStateE                dozeState
);

  //////////////////////////////
  // Internal links
  //////////////////////////////

  logic wakeUp;
  logic armed;
  logic causeClr;

  settleIf settleBus ();

  //////////////////////////////
  // Instances
  //////////////////////////////

  wakeSourceMonitor uWakeSourceMonitor
  (
    .macLPClk               (macLPClk),
    .macCoreClkHardRst_n    (macCoreClkHardRst_n),
    .macCoreClkSoftRst_n    (macCoreClkSoftRst_n),
    .wakeupListenInterval_p (wakeupListenInterval_p),
    .wakeupDTIM_p           (wakeupDTIM_p),
    .atimWindowOver_p       (atimWindowOver_p),
    .absGenTimersInt        (absGenTimersInt),
    .wakeUpFromDoze         (wakeUpFromDoze),
    .wakeEnMask             (wakeEnMask),
    .armed                  (armed),
    .causeClr               (causeClr),
    .wakeUp                 (wakeUp),
    .wakeCause              (wakeCause)
  );

  // Settle durations come from the top parameters
  clkSettleTimer
  #(
    .counterWidth (counterWidth),
    .toLpCycles   (toLpCycles),
    .toFastCycles (toFastCycles)
  )
  uClkSettleTimer
  (
    .macLPClk            (macLPClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .macCoreClkSoftRst_n (macCoreClkSoftRst_n),
    .settle              (settleBus.timer)
  );

  dozeController uDozeController
  (
    .macLPClk            (macLPClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .macCoreClkSoftRst_n (macCoreClkSoftRst_n),
    .moveToDoze_p        (moveToDoze_p),
    .wakeUp              (wakeUp),
    .wakeUpSW            (wakeUpSW),
    .wakeUpFromDoze      (wakeUpFromDoze),
    .enableLPClkSwitch   (enableLPClkSwitch),
    .activeClkGating     (activeClkGating),
    .nextState           (nextState),
    .fastClkStable       (fastClkStable),
    .settle              (settleBus.ctrl),
    .armed               (armed),
    .causeClr            (causeClr),
    .dozeWakeUp_p        (dozeWakeUp_p),
    .macPriClkEn         (macPriClkEn),
    .macSecClkEn         (macSecClkEn),
    .platformWakeUp      (platformWakeUp),
    .macLPClkSwitch      (macLPClkSwitch),
    .dozeState           (dozeState)
  );

endmodule

/* src/dozeController.sv */
/*
  Doze sequencer FSM on macLPClk.
  Clock enables are registered, one cycle behind the state.
  platformWakeUp, macLPClkSwitch and dozeWakeUp_p decode the current state.
  nextState equal to zero releases the core from DOZE or WAITSWREQ.
*/

module dozeController
(
  input  logic               macLPClk,
  input  logic               macCoreClkHardRst_n,
  input  logic               macCoreClkSoftRst_n,
  // MAC controller request
  input  logic               moveToDoze_p,
  // Masked wake level from the monitor
  input  logic               wakeUp,
  // Register controls
  input  logic               wakeUpSW,
  input  logic               wakeUpFromDoze,
  input  logic               enableLPClkSwitch,
  input  logic               activeClkGating,
  input  logic [3:0]         nextState,
  // Clock controller status
  input  logic               fastClkStable,
  settleIf.ctrl              settle,
  // To the monitor
  output logic               armed,
  output logic               causeClr,
  output logic               dozeWakeUp_p,
  output logic               macPriClkEn,
  output logic               macSecClkEn,
  output logic               platformWakeUp,
  output logic               macLPClkSwitch,
  output dozePkg::dozeStateE dozeState
);

  //////////////////////////////
  // State register
  //////////////////////////////

  dozePkg::dozeStateE stateCs;
  dozePkg::dozeStateE stateNs;

  logic swRelease;
  logic enterDoze;
  logic leaveDoze;
  logic gateState;

  always_ff @(posedge macLPClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      stateCs <= dozePkg::IDLE;
    else if (!macCoreClkSoftRst_n)
      stateCs <= dozePkg::IDLE;
    else
      stateCs <= stateNs;
  end

  //////////////////////////////
  // Transition conditions
  //////////////////////////////

  // Software moved the core back to IDLE
  assign swRelease = (nextState == 4'd0);

  // Timer must be free before a new settle is requested
  assign enterDoze = (stateCs == dozePkg::IDLE) && moveToDoze_p && !settle.busy;

  // Both exits towards the fast clock
  assign leaveDoze = !settle.busy &&
                     (((stateCs == dozePkg::DOZE) && ((wakeUp && !wakeUpSW) || swRelease)) ||
                      ((stateCs == dozePkg::WAITSWREQ) && swRelease));

  always_comb
  begin
    stateNs = stateCs;
    case (stateCs)
      dozePkg::IDLE:
        if (enterDoze)
          stateNs = dozePkg::SWITCHTO32K;
      // Wait for the slow clock to settle
      dozePkg::SWITCHTO32K:
        if (settle.done)
          stateNs = dozePkg::SWITCHOFFCLK;
      // One cycle only
      dozePkg::SWITCHOFFCLK:
        stateNs = dozePkg::DOZE;
      dozePkg::DOZE:
        // Software wants to see the wake first
        if (wakeUp && wakeUpSW && !swRelease)
          stateNs = dozePkg::WAITSWREQ;
        else if (leaveDoze)
          stateNs = dozePkg::SWITCHTOFASTCLK;
      dozePkg::WAITSWREQ:
        if (leaveDoze)
          stateNs = dozePkg::SWITCHTOFASTCLK;
      dozePkg::SWITCHTOFASTCLK:
        if (settle.done)
          stateNs = dozePkg::SWITCHONCLK;
      // Held here until the fast clock is stable
      dozePkg::SWITCHONCLK:
        if (fastClkStable)
          stateNs = dozePkg::IDLE;
      default:
        stateNs = dozePkg::IDLE;
    endcase
  end

  //////////////////////////////
  // Settle timer requests
  //////////////////////////////

  assign settle.start = enterDoze || leaveDoze;
  // Only IDLE times the slow clock switch
  assign settle.phase = (stateCs == dozePkg::IDLE) ? dozePkg::TO_LP : dozePkg::TO_FAST;

  //////////////////////////////
  // Wake monitor control
  //////////////////////////////

  // Old causes dropped at doze entry
  assign causeClr = enterDoze;
  assign armed    = (stateCs == dozePkg::DOZE) || (stateCs == dozePkg::WAITSWREQ);

  //////////////////////////////
  // Clock enables
  //////////////////////////////

  // States where the primary clocks may be off
  assign gateState = (stateCs == dozePkg::SWITCHOFFCLK) ||
                     (stateCs == dozePkg::DOZE) ||
                     (stateCs == dozePkg::WAITSWREQ);

  always_ff @(posedge macLPClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      macPriClkEn <= 1'b1;
    else if (!macCoreClkSoftRst_n)
      macPriClkEn <= 1'b1;
    // Register wake keeps the primary clocks running
    else if (activeClkGating)
      macPriClkEn <= !(gateState && !wakeUpFromDoze);
    else
      macPriClkEn <= 1'b1;
  end

  // Secondary clocks go off first and come back after the primary
  always_ff @(posedge macLPClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      macSecClkEn <= 1'b1;
    else if (!macCoreClkSoftRst_n)
      macSecClkEn <= 1'b1;
    else if (activeClkGating)
    begin
      if ((stateCs == dozePkg::SWITCHTO32K) || (stateCs == dozePkg::SWITCHOFFCLK))
        macSecClkEn <= 1'b0;
      else
        macSecClkEn <= macPriClkEn;
    end
    else
      macSecClkEn <= 1'b1;
  end

  //////////////////////////////
  // State decoded outputs
  //////////////////////////////

  assign platformWakeUp = !((stateCs == dozePkg::SWITCHOFFCLK) || (stateCs == dozePkg::DOZE));

  // LP clock selected only on the way down and in DOZE
  assign macLPClkSwitch = ((stateCs == dozePkg::SWITCHTO32K) ||
                           (stateCs == dozePkg::SWITCHOFFCLK) ||
                           (stateCs == dozePkg::DOZE)) ? enableLPClkSwitch : 1'b0;

  // Last SWITCHONCLK cycle
  assign dozeWakeUp_p = (stateCs == dozePkg::SWITCHONCLK) && fastClkStable;

  assign dozeState = stateCs;

endmodule

/* src/clkSettleTimer.sv */
/*
  Down-counter timing clock switch settling in macLPClk cycles.
  toLpCycles and toFastCycles must be at least 1 and fit in counterWidth bits.
  done rises exactly N cycles after the edge that samples start.
  A start while busy reloads the count; the controller never does this.
*/

module clkSettleTimer
#(
  parameter int counterWidth = 8,
  parameter int toLpCycles   = 6,
  parameter int toFastCycles = 4
)
(
  input  logic    macLPClk,
  input  logic    macCoreClkHardRst_n,
  input  logic    macCoreClkSoftRst_n,
  settleIf.timer  settle
);

  //////////////////////////////
  // Count state
  //////////////////////////////

  logic [counterWidth-1:0] count;
  logic [counterWidth-1:0] loadVal;
  logic                    lastTick;
  logic                    doneReg;

  // Duration picked by the phase sampled with start
  assign loadVal = (settle.phase == dozePkg::TO_FAST) ? counterWidth'(toFastCycles)
                                                      : counterWidth'(toLpCycles);

  // Final counted cycle
  assign lastTick = (count == counterWidth'(1));

  always_ff @(posedge macLPClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      count <= '0;
    else if (!macCoreClkSoftRst_n)
      count <= '0;
    else if (settle.start)
      count <= loadVal;
    // Stops at zero and stays idle
    else if (count != '0)
      count <= count - counterWidth'(1);
  end

  //////////////////////////////
  // Status to the controller
  //////////////////////////////

  // Registered so done lands one cycle after the last count
  always_ff @(posedge macLPClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      doneReg <= 1'b0;
    else if (!macCoreClkSoftRst_n)
      doneReg <= 1'b0;
    else
      doneReg <= lastTick && !settle.start;
  end

  // High for the N loaded cycles
  assign settle.busy = (count != '0);
  assign settle.done = doneReg;

endmodule

/* src/wakeSourceMonitor.sv */
/*
  Masks and combines the wake sources on macLPClk.
  All sources must already be synchronous to macLPClk.
  wakeUp is a registered level that follows the masked OR with one cycle of delay.
  Causes are sticky until causeClr and only captured while armed.
*/

module wakeSourceMonitor
(
  input  logic                              macLPClk,
  input  logic                              macCoreClkHardRst_n,
  input  logic                              macCoreClkSoftRst_n,
  // Timer unit sources
  input  logic                              wakeupListenInterval_p,
  input  logic                              wakeupDTIM_p,
  input  logic                              atimWindowOver_p,
  input  logic                              absGenTimersInt,
  // Register wake
  input  logic                              wakeUpFromDoze,
  input  logic [dozePkg::NUM_WAKE_SRC-1:0]  wakeEnMask,
  // From the doze controller
  input  logic                              armed,
  input  logic                              causeClr,
  output logic                              wakeUp,
  output logic [dozePkg::NUM_WAKE_SRC-1:0]  wakeCause
);

  //////////////////////////////
  // Source vector
  //////////////////////////////

  // Bit order matches wakeEnMask and wakeCause
  // 0 listen interval, 1 DTIM, 2 ATIM over, 3 abs timer, 4 register
  logic [dozePkg::NUM_WAKE_SRC-1:0] srcVec;
  logic [dozePkg::NUM_WAKE_SRC-1:0] enSrc;

  assign srcVec = {wakeUpFromDoze,
                   absGenTimersInt,
                   atimWindowOver_p,
                   wakeupDTIM_p,
                   wakeupListenInterval_p};

  // Disabled sources never reach the controller
  assign enSrc = srcVec & wakeEnMask;

  //////////////////////////////
  // Wake level
  //////////////////////////////

  always_ff @(posedge macLPClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      wakeUp <= 1'b0;
    else if (!macCoreClkSoftRst_n)
      wakeUp <= 1'b0;
    else
      wakeUp <= |enSrc;
  end

  //////////////////////////////
  // Sticky cause register
  //////////////////////////////

  always_ff @(posedge macLPClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      wakeCause <= '0;
    else if (!macCoreClkSoftRst_n)
      wakeCause <= '0;
    // Clear wins over a capture in the same cycle
    else if (causeClr)
      wakeCause <= '0;
    else if (armed)
      wakeCause <= wakeCause | enSrc;
  end

endmodule

/* src/settleIf.sv */
/*
  Link between the doze controller and the clock settle timer.
  start is a single-cycle pulse, raised only while busy is low.
  phase is only meaningful in the cycle that carries start.
*/

interface settleIf;

  // Request pulse from the controller
  logic start;
  // Switch direction, qualified by start
  dozePkg::settlePhaseE phase;
  // Timer counting
  logic busy;
  // End of count pulse
  logic done;

  // Controller side
  modport ctrl
  (
    output start,
    output phase,
    input  busy,
    input  done
  );

  // Timer side
  modport timer
  (
    input  start,
    input  phase,
    output busy,
    output done
  );

endinterface

/* src/dozePkg.sv */
/*
  Shared types and constants for the doze sequencer.
  State encodings are 3 bits and the settle phase is 1 bit. The debug
  output and the bound checks depend on these widths.
  NUM_WAKE_SRC is fixed by the wake source wiring in the monitor.
*/

package dozePkg;

  //////////////////////////////
  // Wake sources
  //////////////////////////////

  // Listen interval, DTIM, ATIM over, absolute timer, register wake
  localparam int NUM_WAKE_SRC = 5;

  //////////////////////////////
  // Sequencer states
  //////////////////////////////

  typedef enum logic [2:0]
  {
    IDLE            = 3'd0,
    // Slow clock switch, settle running
    SWITCHTO32K     = 3'd1,
    // Single cycle, primary clocks go off
    SWITCHOFFCLK    = 3'd2,
    DOZE            = 3'd3,
    // Woken, software still holds the core
    WAITSWREQ       = 3'd4,
    SWITCHTOFASTCLK = 3'd5,
    // Waits for the clock controller
    SWITCHONCLK     = 3'd6
  } dozeStateE;

  //////////////////////////////
  // Settle direction
  //////////////////////////////

  typedef enum logic
  {
    TO_LP   = 1'b0,
    TO_FAST = 1'b1
  } settlePhaseE;

endpackage
